// ==== verilog/rv_exec_pkg.sv ====
package rv_exec_pkg;

  // Datapath width
  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;

  localparam logic [6:0] op_rtype = 7'b0110011; // R-type arithmetic

  // Branch conditions
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // R-type operations
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_srl  = 3'b101; // SRA shares this code
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // funct7 selectors
  localparam logic [6:0] f7_alt    = 7'b0100000; // SUB, SRA
  localparam logic [6:0] f7_muldiv = 7'b0000001; // M extension

  // Shift-add iterations, one per multiplier bit
  localparam int mul_cycles = 32;

endpackage

// ==== verilog/t04_mul_if.sv ====
interface t04_mul_if;

  logic                 start;   // One-cycle request
  rv_exec_pkg::word_t   a;       // Multiplicand
  rv_exec_pkg::word_t   b;       // Multiplier
  logic                 done;    // One-cycle completion
  rv_exec_pkg::word_t   product; // Low word, valid with done

  modport seq (
    output start, a, b,
    input  done, product
  );

  modport mul (
    input  start, a, b,
    output done, product
  );

endinterface

// ==== verilog/t04_fa32.sv ====
module t04_fa32 (
  input  rv_exec_pkg::word_t a,
  input  rv_exec_pkg::word_t b,
  input  logic               cin,
  output rv_exec_pkg::word_t s,
  output logic               cout
);

  logic [rv_exec_pkg::xlen:0] carry; // Ripple chain

  assign carry[0] = cin;

  // One full adder cell per bit
  for (genvar i = 0; i < rv_exec_pkg::xlen; i++) begin : g_bit
    assign s[i]       = a[i] ^ b[i] ^ carry[i];
    assign carry[i+1] = (a[i] & b[i]) | (carry[i] & (a[i] ^ b[i]));
  end

  assign cout = carry[rv_exec_pkg::xlen];

endmodule

// ==== verilog/t04_alu.sv ====
module t04_alu (
  input  rv_exec_pkg::word_t src_a,
  input  rv_exec_pkg::word_t src_b,
  input  rv_exec_pkg::word_t instruction,
  input  logic               alu_control,
  output rv_exec_pkg::word_t alu_result,
  output logic               branch_flag,
  output logic               mul_en
);

  rv_exec_pkg::word_t sub_result;
  logic               sub_cout;
  logic               sub_ovf;
  logic               lt_signed;
  logic               lt_unsigned;
  logic [6:0]         opcode;
  logic [6:0]         funct7;
  logic [2:0]         funct3;

  assign opcode = instruction[6:0];
  assign funct3 = instruction[14:12];
  assign funct7 = instruction[31:25];

  // A - B as A + ~B + 1
  t04_fa32 u_sub (
    .a    (src_a),
    .b    (~src_b),
    .cin  (1'b1),
    .s    (sub_result),
    .cout (sub_cout)
  );

  // Overflow when operand signs differ and the result sign flips from A
  assign sub_ovf     = (src_a[31] ^ src_b[31]) & (sub_result[31] ^ src_a[31]);
  assign lt_signed   = sub_result[31] ^ sub_ovf;
  assign lt_unsigned = ~sub_cout; // No carry out means a borrow

  always_comb begin
    alu_result  = '0;
    branch_flag = 1'b0;
    mul_en      = 1'b0;

    if (alu_control) begin
      alu_result = sub_result; // Branches report the difference
      case (funct3)
        rv_exec_pkg::f3_beq:  branch_flag = (sub_result == '0);
        rv_exec_pkg::f3_bne:  branch_flag = (sub_result != '0);
        rv_exec_pkg::f3_blt:  branch_flag = lt_signed;
        rv_exec_pkg::f3_bge:  branch_flag = ~lt_signed;
        rv_exec_pkg::f3_bltu: branch_flag = lt_unsigned;
        rv_exec_pkg::f3_bgeu: branch_flag = ~lt_unsigned;
        default:              branch_flag = 1'b0;
      endcase
    end else if (opcode == rv_exec_pkg::op_rtype) begin
      case (funct3)
        rv_exec_pkg::f3_add: begin
          if (funct7 == rv_exec_pkg::f7_muldiv) begin
            mul_en = 1'b1; // Product comes from the multiplier
          end else if (funct7 == rv_exec_pkg::f7_alt) begin
            alu_result = sub_result;
          end else begin
            alu_result = src_a + src_b;
          end
        end
        rv_exec_pkg::f3_sll:  alu_result = src_a << src_b[4:0];
        rv_exec_pkg::f3_slt:  alu_result = {31'd0, lt_signed};
        rv_exec_pkg::f3_sltu: alu_result = {31'd0, lt_unsigned};
        rv_exec_pkg::f3_xor:  alu_result = src_a ^ src_b;
        rv_exec_pkg::f3_srl: begin
          if (funct7 == rv_exec_pkg::f7_alt)
            alu_result = $signed(src_a) >>> src_b[4:0]; // SRA
          else
            alu_result = src_a >> src_b[4:0];
        end
        rv_exec_pkg::f3_or:   alu_result = src_a | src_b;
        rv_exec_pkg::f3_and:  alu_result = src_a & src_b;
        default:              alu_result = '0;
      endcase
    end else begin
      // Loads, stores, ADDI and the like
      alu_result = src_a + src_b;
    end
  end

endmodule

// ==== verilog/t04_multiplier.sv ====
module t04_multiplier (
  input logic clk,
  input logic rst,
  t04_mul_if.mul mul
);

  localparam int cnt_w = $clog2(rv_exec_pkg::mul_cycles);

  rv_exec_pkg::word_t mcand;  // Shifts left each step
  rv_exec_pkg::word_t mplier; // Shifts right each step
  rv_exec_pkg::word_t acc;
  logic [cnt_w-1:0]   count;
  logic               running;
  logic               done_q;

  // Control state
  always_ff @(posedge clk) begin
    if (rst) begin
      running <= 1'b0;
      done_q  <= 1'b0;
      count   <= '0;
    end else begin
      done_q <= 1'b0;
      if (mul.start) begin
        running <= 1'b1;
        count   <= cnt_w'(1); // Bit 0 handled in the load cycle
      end else if (running) begin
        count <= count + 1'b1;
        if (count == cnt_w'(rv_exec_pkg::mul_cycles - 1)) begin
          running <= 1'b0;
          done_q  <= 1'b1;
        end
      end
    end
  end

  // Datapath, low word only
  always_ff @(posedge clk) begin
    if (mul.start) begin
      acc    <= mul.b[0] ? mul.a : '0;
      mcand  <= mul.a << 1;
      mplier <= mul.b >> 1;
    end else if (running) begin
      if (mplier[0])
        acc <= acc + mcand;
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  assign mul.done    = done_q;
  assign mul.product = acc;

endmodule

// ==== verilog/t04_exec_seq.sv ====
module t04_exec_seq (
  input  logic               clk,
  input  logic               rst,
  input  logic               issue,
  input  rv_exec_pkg::word_t src_a,
  input  rv_exec_pkg::word_t src_b,
  input  rv_exec_pkg::word_t alu_result,
  input  logic               branch_flag,
  input  logic               mul_en,
  output rv_exec_pkg::word_t result,
  output logic               branch_taken,
  output logic               done,
  output logic               busy,
  t04_mul_if.seq             mul
);

  typedef enum logic {st_idle, st_mul} state_t;

  state_t state;

  assign busy = (state == st_mul);

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= st_idle;
      done         <= 1'b0;
      mul.start    <= 1'b0;
      result       <= '0;
      branch_taken <= 1'b0;
    end else begin
      done      <= 1'b0;
      mul.start <= 1'b0;
      case (state)
        st_idle: begin
          if (issue && mul_en) begin
            mul.start <= 1'b1;
            state     <= st_mul;
          end else if (issue) begin
            result       <= alu_result; // Single-cycle path
            branch_taken <= branch_flag;
            done         <= 1'b1;
          end
        end
        st_mul: begin
          // Issues are dropped here
          if (mul.done) begin
            result       <= mul.product;
            branch_taken <= 1'b0;
            done         <= 1'b1;
            state        <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Operands captured with the start pulse
  always_ff @(posedge clk) begin
    if (!busy && issue && mul_en) begin
      mul.a <= src_a;
      mul.b <= src_b;
    end
  end

endmodule

// ==== verilog/t04_execute.sv ====
module t04_execute (
  input  logic               clk,
  input  logic               rst,
  input  logic               issue,
  input  logic               alu_control,
  input  rv_exec_pkg::word_t src_a,
  input  rv_exec_pkg::word_t src_b,
  input  rv_exec_pkg::word_t instruction,
  output rv_exec_pkg::word_t result,
  output logic               branch_taken,
  output logic               done,
  output logic               busy
);

  rv_exec_pkg::word_t alu_result;
  logic               branch_flag;
  logic               mul_en;

  t04_mul_if mul_bus ();

  t04_alu u_alu (
    .src_a       (src_a),
    .src_b       (src_b),
    .instruction (instruction),
    .alu_control (alu_control),
    .alu_result  (alu_result),
    .branch_flag (branch_flag),
    .mul_en      (mul_en)
  );

  t04_exec_seq u_seq (
    .clk          (clk),
    .rst          (rst),
    .issue        (issue),
    .src_a        (src_a),
    .src_b        (src_b),
    .alu_result   (alu_result),
    .branch_flag  (branch_flag),
    .mul_en       (mul_en),
    .result       (result),
    .branch_taken (branch_taken),
    .done         (done),
    .busy         (busy),
    .mul          (mul_bus.seq)
  );

  t04_multiplier u_mul (
    .clk (clk),
    .rst (rst),
    .mul (mul_bus.mul)
  );

endmodule

// ==== test/t04_execute_assert.sv ====
module t04_execute_assert (
  input logic clk,
  input logic rst,
  input logic issue,
  input logic mul_en,
  input logic busy,
  input logic done,
  input logic start,
  input logic mul_done
);
  timeunit 1ns;
  timeprecision 1ps;

  int assert_errors = 0; // Failed assertions so far

  // Start only leaves the sequencer from idle
  start_from_idle: assert property (@(posedge clk) disable iff (rst)
    start |-> !$past(busy))
    else begin
      assert_errors++;
      $error("multiplier start raised while the sequencer was busy");
    end

  mul_done_after_start: assert property (@(posedge clk) disable iff (rst)
    start |-> ##(rv_exec_pkg::mul_cycles) mul_done)
    else begin
      assert_errors++;
      $error("multiplier done missing mul_cycles after start");
    end

  // No early or stray done from the multiplier
  mul_done_only_after_start: assert property (@(posedge clk) disable iff (rst)
    mul_done |-> $past(start, rv_exec_pkg::mul_cycles))
    else begin
      assert_errors++;
      $error("multiplier done without a start mul_cycles earlier");
    end

  no_done_with_mul_issue: assert property (@(posedge clk) disable iff (rst)
    !(done && issue && mul_en && !busy))
    else begin
      assert_errors++;
      $error("done high together with an accepted multiply issue");
    end

endmodule

bind t04_execute t04_execute_assert u_assert (
  .clk      (clk),
  .rst      (rst),
  .issue    (issue),
  .mul_en   (mul_en),
  .busy     (busy),
  .done     (done),
  .start    (mul_bus.start),
  .mul_done (mul_bus.done)
);

// ==== test/t04_execute_tb.sv ====
module t04_execute_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int done_timeout = 100;
  localparam int mul_latency  = rv_exec_pkg::mul_cycles + 2; // Issue to done

  logic               clk;
  logic               rst;
  logic               issue;
  logic               alu_control;
  rv_exec_pkg::word_t src_a;
  rv_exec_pkg::word_t src_b;
  rv_exec_pkg::word_t instruction;
  rv_exec_pkg::word_t result;
  logic               branch_taken;
  logic               done;
  logic               busy;

  int check_errors = 0;
  int other_errors = 0;
  int done_pulses  = 0;
  int vectors      = 0;

  t04_execute u_dut (
    .clk          (clk),
    .rst          (rst),
    .issue        (issue),
    .alu_control  (alu_control),
    .src_a        (src_a),
    .src_b        (src_b),
    .instruction  (instruction),
    .result       (result),
    .branch_taken (branch_taken),
    .done         (done),
    .busy         (busy)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Every done pulse, including any stray one
  always @(negedge clk) begin
    if (!rst && done)
      done_pulses++;
  end

  task automatic check_word(input string field, input rv_exec_pkg::word_t expected,
                            input rv_exec_pkg::word_t actual);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s expected %08h, got %08h",
               $time, field, expected, actual);
      check_errors++;
    end
  endtask

  task automatic check_flag(input string field, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s expected %b, got %b", $time, field, expected, actual);
      check_errors++;
    end
  endtask

  task automatic check_count(input string field, input int expected, input int actual);
    if (actual != expected) begin
      $display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, field, expected, actual);
      check_errors++;
    end
  endtask

  task automatic run_vector(input rv_exec_pkg::word_t instr, input logic ctrl,
                            input rv_exec_pkg::word_t a, input rv_exec_pkg::word_t b,
                            input rv_exec_pkg::word_t exp_result, input logic exp_flag);
    int   cycles;
    bit   seen;
    logic is_mul;
    is_mul = !ctrl && (instr[6:0] == rv_exec_pkg::op_rtype)
             && (instr[14:12] == rv_exec_pkg::f3_add)
             && (instr[31:25] == rv_exec_pkg::f7_muldiv);
    @(negedge clk);
    instruction = instr;
    alu_control = ctrl;
    src_a       = a;
    src_b       = b;
    issue       = 1'b1;
    cycles      = 0;
    seen        = 1'b0;
    while (!seen && cycles < done_timeout) begin
      @(negedge clk);
      cycles++;
      if (done) begin
        seen = 1'b1;
      end else begin
        check_flag("busy while waiting", is_mul, busy);
      end
      if (cycles == 1)
        issue = 1'b0;
      if (is_mul && cycles == 5)
        issue = 1'b1; // Must be dropped while busy
      if (is_mul && cycles == 6)
        issue = 1'b0;
    end
    issue = 1'b0;
    if (seen) begin
      check_word("result", exp_result, result);
      check_flag("branch_taken", exp_flag, branch_taken);
      check_flag("busy at done", 1'b0, busy);
      check_count("latency", is_mul ? mul_latency : 1, cycles);
    end else begin
      $display("Timeout: no done within %0d cycles for instruction %08h", done_timeout, instr);
      other_errors++;
    end
  endtask

  initial begin
    int                 fd;
    int                 n;
    int                 gap;
    int                 assert_fails;
    string              line;
    rv_exec_pkg::word_t instr;
    rv_exec_pkg::word_t a;
    rv_exec_pkg::word_t b;
    rv_exec_pkg::word_t exp_result;
    logic               ctrl;
    logic               exp_flag;

    rst          = 1'b1;
    issue        = 1'b0;
    alu_control  = 1'b0;
    src_a        = '0;
    src_b        = '0;
    instruction  = '0;
    void'($urandom(19089));

    repeat (16) @(negedge clk);
    rst = 1'b0;

    fd = $fopen("test/t04_execute_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test data file test/t04_execute_testdata.txt");
      other_errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) == 0)
          break;
        n = $sscanf(line, "%h %h %h %h %h %h", instr, ctrl, a, b, exp_result, exp_flag);
        if (n == 6) begin
          gap = int'($urandom_range(3, 0)); // Idle gap
          repeat (gap) @(negedge clk);
          run_vector(instr, ctrl, a, b, exp_result, exp_flag);
          vectors++;
        end else if (n > 0) begin
          $display("Malformed line in test data file: %s", line);
          other_errors++;
        end
      end
      $fclose(fd);
    end

    // Let any stray done show up
    repeat (4) @(negedge clk);
    check_count("done pulses", vectors, done_pulses);

    assert_fails = u_dut.u_assert.assert_errors;
    $display("Errors: %0d check, %0d other, %0d assertion over %0d vectors",
             check_errors, other_errors, assert_fails, vectors);
    if (check_errors + other_errors + assert_fails == 0 && vectors > 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
verilog/rv_exec_pkg.sv
verilog/t04_mul_if.sv
verilog/t04_fa32.sv
verilog/t04_alu.sv
verilog/t04_multiplier.sv
verilog/t04_exec_seq.sv
verilog/t04_execute.sv
test/t04_execute_assert.sv
test/t04_execute_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f compile.f --top-module t04_execute_tb -o sim_tb

# A failing run may exit nonzero; the pass message decides
out=$(./obj_dir/sim_tb +verilator+error+limit+100) || true
echo "$out"

if echo "$out" | grep -qF '*** TEST PASSED ***'; then
  exit 0
fi
exit 1

// ==== test/t04_execute_testdata.txt ====
# instruction alu_control src_a src_b expected_result expected_branch_taken
# all fields hex, one vector per line
00208063 1 00000005 00000005 00000000 1
00209063 1 00000005 00000003 00000002 1
0020C063 1 FFFFFFFE 00000003 FFFFFFFB 1
0020C063 1 80000000 00000001 7FFFFFFF 1
0020D063 1 7FFFFFFF FFFFFFFF 80000000 1
0020D063 1 00000003 00000007 FFFFFFFC 0
0020E063 1 00000001 FFFFFFFF 00000002 1
0020F063 1 80000000 00000001 7FFFFFFF 1
0020F063 1 00000004 00000009 FFFFFFFB 0
002081B3 0 7FFFFFFF 00000001 80000000 0
402081B3 0 00000000 00000001 FFFFFFFF 0
0020F1B3 0 F0F0F0F0 0FF00FF0 00F000F0 0
0020E1B3 0 F0F0F0F0 0FF00FF0 FFF0FFF0 0
0020C1B3 0 12345678 FFFF0000 EDCB5678 0
0020A1B3 0 FFFFFFFF 00000001 00000001 0
0020B1B3 0 FFFFFFFF 00000001 00000000 0
002091B3 0 00000001 00000024 00000010 0
0020D1B3 0 80000000 0000001F 00000001 0
4020D1B3 0 80000000 00000024 F8000000 0
0000A183 0 00001000 00000010 00001010 0
0020A023 0 FFFFFFFC 00000008 00000004 0
00508193 0 7FFFFFFF 00000005 80000004 0
022081B3 0 00000006 00000007 0000002A 0
022081B3 0 FFFFFFFD 00000005 FFFFFFF1 0
022081B3 0 FFFFFFFF FFFFFFFF 00000001 0
022081B3 0 0000FFFF 0000FFFF FFFE0001 0
